// ==== design/sc_pkg.sv ====
`default_nettype none

package sc_pkg;

	////////////////////////////////////////////////////////////////////
	// USB command word
	////////////////////////////////////////////////////////////////////

	localparam int CMD_W = 16;
	localparam int OP_W  = 4;                          // Top nibble of a command

	localparam logic [OP_W-1:0] OP_DAC_GAIN   = 4'h1;  // Gain DAC, 10 bit
	localparam logic [OP_W-1:0] OP_DAC_TRIG   = 4'h2;  // Trigger DAC, 10 bit
	localparam logic [OP_W-1:0] OP_FB_CAP     = 4'h3;  // Feedback cap select
	localparam logic [OP_W-1:0] OP_DELAY_TRIG = 4'h4;  // Trigger delay
	localparam logic [OP_W-1:0] OP_FLAGS      = 4'h5;  // Bit 1 val_evt, bit 0 only_ex_trig
	localparam logic [OP_W-1:0] OP_MASK       = 4'h6;  // Bits 10..8 index, 7..0 mask byte
	localparam logic [OP_W-1:0] OP_START      = 4'h7;  // Kick one SC frame

	////////////////////////////////////////////////////////////////////
	// Slow-control frame
	////////////////////////////////////////////////////////////////////

	localparam int BYTE_W         = 8;
	localparam int SC_FRAME_BITS  = 112;
	localparam int SC_FRAME_BYTES = SC_FRAME_BITS / BYTE_W;     // 14
	localparam int BYTE_CNT_W     = $clog2(SC_FRAME_BYTES);
	localparam int BIT_CNT_W      = $clog2(BYTE_W);

	localparam logic [7:0] CHIP_ID        = 8'h01;  // Fixed, top of every frame
	localparam logic [7:0] DELAY_TRIG_RST = 8'h70;

	// Serial clock, low half then high half
	localparam int SR_CLK_DIV = 4;
	localparam int DIV_CNT_W  = $clog2(SR_CLK_DIV);

	// Configuration registers as seen by the packer
	typedef struct packed {
		logic [9:0]  dac_gain;
		logic [9:0]  dac_trig;
		logic [3:0]  fb_cap;
		logic [7:0]  delay_trig;
		logic        val_evt;       // Discriminator enable
		logic        only_ex_trig;  // External trigger only
		logic [63:0] mask;          // Byte 0 is the low byte
	} sc_cfg_t;

	// One frame byte on its way to the shifter
	typedef struct packed {
		logic [BYTE_W-1:0] data;
		logic              last;    // Final byte of the frame
	} sc_byte_t;

	// Power-up configuration, discriminator on
	localparam sc_cfg_t CFG_RST = '{
		dac_gain:     10'd0,
		dac_trig:     10'd0,
		fb_cap:       4'd0,
		delay_trig:   DELAY_TRIG_RST,
		val_evt:      1'b1,
		only_ex_trig: 1'b0,
		mask:         64'd0
	};

endpackage

`default_nettype wire

// ==== design/sc_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module sc_cmd_decoder (
	input  wire                       Clk_Out_2_All,
	input  wire                       reset_i,
	input  wire [sc_pkg::CMD_W-1:0]   cmd_i,        // USB control word
	input  wire                       cmd_valid_i,  // One word per strobe
	output sc_pkg::sc_cfg_t           cfg_o,        // Held config level
	output logic                      start_o       // One-cycle frame request
);

	////////////////////////////////////////////////////////////////////
	// Word split
	////////////////////////////////////////////////////////////////////

	logic [sc_pkg::OP_W-1:0] opcode;
	logic [2:0]              mask_idx;
	logic [5:0]              mask_lsb;

	assign opcode   = cmd_i[sc_pkg::CMD_W-1 -: sc_pkg::OP_W];
	assign mask_idx = cmd_i[10:8];          // Which of the 8 mask bytes
	assign mask_lsb = {mask_idx, 3'b000};   // Byte index times 8

	////////////////////////////////////////////////////////////////////
	// Config registers
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (reset_i)
		begin
			cfg_o   <= sc_pkg::CFG_RST;
			start_o <= 1'b0;
		end
		else
		begin
			// Start is a pulse, never held
			start_o <= cmd_valid_i && (opcode == sc_pkg::OP_START);

			if (cmd_valid_i)
			begin
				case (opcode)
					sc_pkg::OP_DAC_GAIN:
						cfg_o.dac_gain <= cmd_i[9:0];
					sc_pkg::OP_DAC_TRIG:
						cfg_o.dac_trig <= cmd_i[9:0];
					sc_pkg::OP_FB_CAP:
						cfg_o.fb_cap <= cmd_i[3:0];     // Low nibble only
					sc_pkg::OP_DELAY_TRIG:
						cfg_o.delay_trig <= cmd_i[7:0];
					sc_pkg::OP_FLAGS:
					begin
						cfg_o.val_evt      <= cmd_i[1];
						cfg_o.only_ex_trig <= cmd_i[0];
					end
					sc_pkg::OP_MASK:
						cfg_o.mask[mask_lsb +: 8] <= cmd_i[7:0];
					default:
					begin
						// Start handled above, unknown words dropped
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/sc_frame_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sc_frame_packer (
	input  wire                Clk_Out_2_All,
	input  wire                reset_i,
	input  wire sc_pkg::sc_cfg_t cfg_i,
	input  wire                start_i,
	input  wire                byte_req_i,    // Shifter wants the next byte
	output sc_pkg::sc_byte_t   byte_o,
	output logic               byte_valid_o,
	output logic               busy_o
);

	logic [sc_pkg::SC_FRAME_BITS-1:0] frame_new;
	logic [sc_pkg::SC_FRAME_BITS-1:0] frame_q;     // Bytes not yet sent, top aligned
	logic [sc_pkg::BYTE_CNT_W-1:0]    cnt_q;       // Index of byte just issued
	logic                             load_first;
	logic                             load_next;
	logic                             next_is_last;

	// Frame layout, MSB first, six pad bits at the tail
	assign frame_new = {sc_pkg::CHIP_ID, cfg_i.delay_trig, cfg_i.dac_trig, cfg_i.dac_gain,
		cfg_i.fb_cap, cfg_i.val_evt, cfg_i.only_ex_trig, cfg_i.mask, 6'b000000};

	assign load_first   = start_i && !busy_o;      // Start during a frame is lost
	assign load_next    = byte_req_i && busy_o;
	assign next_is_last = (cnt_q == sc_pkg::BYTE_CNT_W'(sc_pkg::SC_FRAME_BYTES - 2));

	////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (reset_i)
		begin
			busy_o       <= 1'b0;
			byte_valid_o <= 1'b0;
			cnt_q        <= '0;
		end
		else
		begin
			byte_valid_o <= load_first || load_next;
			if (load_first)
			begin
				busy_o <= 1'b1;
				cnt_q  <= '0;
			end
			else if (load_next)
			begin
				cnt_q <= cnt_q + 1'b1;
				if (next_is_last)
					busy_o <= 1'b0;  // Byte 13 leaves now
			end
		end
	end

	// Frame shift and output byte
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (load_first)
		begin
			byte_o.data <= frame_new[sc_pkg::SC_FRAME_BITS-1 -: sc_pkg::BYTE_W];
			byte_o.last <= 1'b0;
			frame_q     <= frame_new << sc_pkg::BYTE_W;   // Frozen copy
		end
		else if (load_next)
		begin
			byte_o.data <= frame_q[sc_pkg::SC_FRAME_BITS-1 -: sc_pkg::BYTE_W];
			byte_o.last <= next_is_last;
			frame_q     <= frame_q << sc_pkg::BYTE_W;
		end
	end

endmodule

`default_nettype wire

// ==== design/sc_sr_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sc_sr_shifter (
	input  wire                  Clk_Out_2_All,
	input  wire                  reset_i,
	input  wire sc_pkg::sc_byte_t byte_i,
	input  wire                  byte_valid_i,
	output logic                 byte_req_o,   // Pulse, next byte please
	output logic                 sr_ck_o,      // Serial clock to the chip
	output logic                 sr_in_o,      // Serial data, MSB first
	output logic                 done_o,       // Pulse at end of frame
	output logic                 busy_o
);

	logic [sc_pkg::BYTE_W-1:0]    shift_q;
	logic                         last_q;
	logic                         active_q;    // Byte in flight
	logic [sc_pkg::DIV_CNT_W-1:0] div_cnt_q;
	logic [sc_pkg::BIT_CNT_W-1:0] bit_cnt_q;
	logic                         ck_rise;
	logic                         bit_end;
	logic                         byte_end;

	////////////////////////////////////////////////////////////////////
	// Bit timing
	////////////////////////////////////////////////////////////////////

	// Low for the first half, high for the second
	assign ck_rise  = active_q &&
		(div_cnt_q == sc_pkg::DIV_CNT_W'(sc_pkg::SR_CLK_DIV / 2 - 1));
	assign bit_end  = active_q &&
		(div_cnt_q == sc_pkg::DIV_CNT_W'(sc_pkg::SR_CLK_DIV - 1));
	assign byte_end = bit_end && (bit_cnt_q == '1);  // Eighth bit done

	always_ff @(posedge Clk_Out_2_All)
	begin
		if (reset_i)
		begin
			active_q   <= 1'b0;
			div_cnt_q  <= '0;
			bit_cnt_q  <= '0;
			sr_ck_o    <= 1'b0;
			sr_in_o    <= 1'b0;
			done_o     <= 1'b0;
			byte_req_o <= 1'b0;
			busy_o     <= 1'b0;
		end
		else
		begin
			done_o     <= 1'b0;
			byte_req_o <= 1'b0;
			if (byte_valid_i)
			begin
				active_q  <= 1'b1;
				busy_o    <= 1'b1;
				div_cnt_q <= '0;
				bit_cnt_q <= '0;
				sr_in_o   <= byte_i.data[sc_pkg::BYTE_W-1];  // Clock is low here
			end
			else if (active_q)
			begin
				div_cnt_q <= div_cnt_q + 1'b1;
				if (ck_rise)
					sr_ck_o <= 1'b1;
				if (bit_end)
				begin
					sr_ck_o   <= 1'b0;
					div_cnt_q <= '0;
					bit_cnt_q <= bit_cnt_q + 1'b1;
					if (byte_end)
					begin
						active_q <= 1'b0;
						if (last_q)
						begin
							done_o  <= 1'b1;
							busy_o  <= 1'b0;
							sr_in_o <= 1'b0;   // Park data line
						end
						else
							byte_req_o <= 1'b1;
					end
					else
						sr_in_o <= shift_q[sc_pkg::BYTE_W-2];  // Next bit on falling clock
				end
			end
		end
	end

	// Shift register and last flag
	always_ff @(posedge Clk_Out_2_All)
	begin
		if (byte_valid_i)
		begin
			shift_q <= byte_i.data;
			last_q  <= byte_i.last;
		end
		else if (bit_end)
			shift_q <= shift_q << 1;
	end

endmodule

`default_nettype wire

// ==== design/sc_config_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sc_config_top (
	input  wire                     Clk_Out_2_All,
	input  wire                     reset_i,
	input  wire [sc_pkg::CMD_W-1:0] cmd_i,
	input  wire                     cmd_valid_i,
	output logic                    sr_ck_o,
	output logic                    sr_in_o,
	output logic                    busy_o,
	output logic                    done_o
);

	sc_pkg::sc_cfg_t  cfg;
	sc_pkg::sc_byte_t sc_byte;
	logic             start;
	logic             start_gated;
	logic             byte_valid;
	logic             byte_req;
	logic             pk_busy;
	logic             sh_busy;

	// Busy spans packer handout and shifter tail
	assign busy_o      = pk_busy | sh_busy;
	assign start_gated = start & ~sh_busy;   // Drop start while last bytes still shift

	////////////////////////////////////////////////////////////////////
	// Decoder, packer, shifter
	////////////////////////////////////////////////////////////////////

	sc_cmd_decoder sc_cmd_decoder_i (
		.Clk_Out_2_All (Clk_Out_2_All),
		.reset_i       (reset_i),
		.cmd_i         (cmd_i),
		.cmd_valid_i   (cmd_valid_i),
		.cfg_o         (cfg),
		.start_o       (start)
	);

	sc_frame_packer sc_frame_packer_i (
		.Clk_Out_2_All (Clk_Out_2_All),
		.reset_i       (reset_i),
		.cfg_i         (cfg),
		.start_i       (start_gated),
		.byte_req_i    (byte_req),
		.byte_o        (sc_byte),
		.byte_valid_o  (byte_valid),
		.busy_o        (pk_busy)
	);

	sc_sr_shifter sc_sr_shifter_i (
		.Clk_Out_2_All (Clk_Out_2_All),
		.reset_i       (reset_i),
		.byte_i        (sc_byte),
		.byte_valid_i  (byte_valid),
		.byte_req_o    (byte_req),
		.sr_ck_o       (sr_ck_o),
		.sr_in_o       (sr_in_o),
		.done_o        (done_o),
		.busy_o        (sh_busy)
	);

endmodule

`default_nettype wire

// ==== verif/tb_sc_config.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sc_config;

	localparam int TIMEOUT_CYCLES = 6000;  // Eight frames of ~470 cycles plus commands

	logic                     Clk_Out_2_All;
	logic                     reset_i;
	logic [sc_pkg::CMD_W-1:0] cmd_i;
	logic                     cmd_valid_i;
	wire                      sr_ck_o;
	wire                      sr_in_o;
	wire                      busy_o;
	wire                      done_o;

	sc_pkg::sc_cfg_t  model_cfg;          // Reference copy of the config registers
	logic [111:0]     rx_bits;            // Serial stream, newest bit at LSB
	int               ck_edges = 0;
	int               done_pulses = 0;
	int               cycles = 0;
	int               errors = 0;
	int               checks = 0;

	sc_config_top sc_config_top_i (
		.Clk_Out_2_All (Clk_Out_2_All),
		.reset_i       (reset_i),
		.cmd_i         (cmd_i),
		.cmd_valid_i   (cmd_valid_i),
		.sr_ck_o       (sr_ck_o),
		.sr_in_o       (sr_in_o),
		.busy_o        (busy_o),
		.done_o        (done_o)
	);

	always #5 Clk_Out_2_All = ~Clk_Out_2_All;

	// Chip side, data taken on the rising serial clock
	always @(posedge sr_ck_o)
	begin
		rx_bits  <= {rx_bits[110:0], sr_in_o};
		ck_edges <= ck_edges + 1;
	end

	always @(posedge Clk_Out_2_All)
	begin
		cycles <= cycles + 1;
		if (done_o === 1'b1)
			done_pulses <= done_pulses + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, done_o never ended the frame", cycles);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("TEST FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and checks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [111:0] expected_frame(input sc_pkg::sc_cfg_t c);
		return {sc_pkg::CHIP_ID, c.delay_trig, c.dac_trig, c.dac_gain, c.fb_cap,
			c.val_evt, c.only_ex_trig, c.mask, 6'b000000};   // MSB first, pad at tail
	endfunction

	task automatic apply_to_model(input logic [15:0] w);
		int idx;
		idx = int'(w[10:8]);
		case (w[15:12])
			sc_pkg::OP_DAC_GAIN:   model_cfg.dac_gain = w[9:0];
			sc_pkg::OP_DAC_TRIG:   model_cfg.dac_trig = w[9:0];
			sc_pkg::OP_FB_CAP:     model_cfg.fb_cap = w[3:0];
			sc_pkg::OP_DELAY_TRIG: model_cfg.delay_trig = w[7:0];
			sc_pkg::OP_FLAGS:      model_cfg.val_evt = w[1];
			sc_pkg::OP_MASK:       model_cfg.mask[idx*8 +: 8] = w[7:0];
			default:               ;  // Start and unused words leave the config alone
		endcase
		if (w[15:12] == sc_pkg::OP_FLAGS)
			model_cfg.only_ex_trig = w[0];
	endtask

	task automatic check_bits(input string name, input logic [111:0] got, input logic [111:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		assert (got == exp)
		else
		begin
			errors++;
			$display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// Single status line, X or Z counts as wrong
	task automatic check_level(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Command and frame tasks
	//////////////////////////////////////////////////////////////////////

	task automatic send_cmd(input logic [3:0] op, input logic [11:0] payload);
		@(posedge Clk_Out_2_All);
		#1;
		cmd_i       = {op, payload};
		cmd_valid_i = 1'b1;
		apply_to_model({op, payload});
		@(posedge Clk_Out_2_All);
		#1;
		cmd_valid_i = 1'b0;
	endtask

	task automatic write_gain(input logic [9:0] v);
		send_cmd(sc_pkg::OP_DAC_GAIN, {2'b00, v});
	endtask

	task automatic write_trig(input logic [9:0] v);
		send_cmd(sc_pkg::OP_DAC_TRIG, {2'b00, v});
	endtask

	task automatic write_mask(input logic [2:0] idx, input logic [7:0] b);
		send_cmd(sc_pkg::OP_MASK, {1'b0, idx, b});
	endtask

	// Done is sampled at the clock edge, busy must drop in the same cycle
	task automatic wait_done();
		int waited;
		waited = 0;
		@(posedge Clk_Out_2_All);
		while (done_o !== 1'b1)
		begin
			// Packer takes the start on the first edge, busy follows
			if (waited > 0)
				check_level("busy_o before done_o", busy_o, 1'b1);
			waited++;
			@(posedge Clk_Out_2_All);
		end
		check_level("busy_o at done_o", busy_o, 1'b0);
		repeat (4) @(posedge Clk_Out_2_All);  // Room for a stray second pulse
	endtask

	task automatic run_frame(input string name);
		logic [111:0] exp;
		int edges_before;
		int dones_before;
		exp          = expected_frame(model_cfg);
		edges_before = ck_edges;
		dones_before = done_pulses;
		send_cmd(sc_pkg::OP_START, 12'h000);
		wait_done();
		check_bits({name, ": sr_in_o frame"}, rx_bits, exp);
		check_count({name, ": sr_ck_o edges"}, ck_edges - edges_before, 112);
		check_count({name, ": done_o pulses"}, done_pulses - dones_before, 1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_defaults();
		check_level("sr_ck_o after reset", sr_ck_o, 1'b0);
		check_level("busy_o after reset", busy_o, 1'b0);
		check_level("done_o after reset", done_o, 1'b0);
		run_frame("default frame");
		check_count("chip id byte", int'(rx_bits[111:104]), int'(sc_pkg::CHIP_ID));
	endtask

	task automatic test_field_writes();
		write_gain(10'h3c5);
		write_trig(10'h1a7);
		send_cmd(sc_pkg::OP_FB_CAP, 12'h00b);
		send_cmd(sc_pkg::OP_DELAY_TRIG, 12'h05e);
		send_cmd(sc_pkg::OP_FLAGS, 12'h001);    // Discriminator off, external only
		run_frame("field writes");
		check_count("dac_gain slice", int'(rx_bits[85:76]), 'h3c5);
	endtask

	task automatic test_mask();
		int order[8];
		int j;
		int tmp;
		for (int i = 0; i < 8; i++)
			order[i] = i;
		for (int i = 7; i > 0; i--)
		begin
			j        = int'($urandom_range(i, 0));  // Shuffle byte order
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < 8; i++)
			write_mask(3'(order[i]), 8'($urandom()));
		run_frame("mask");
		check_bits("mask slice", {48'd0, rx_bits[69:6]}, {48'd0, model_cfg.mask});
	endtask

	task automatic test_frozen_frame();
		logic [111:0] exp_old;
		int edges_before;
		int dones_before;
		exp_old      = expected_frame(model_cfg);
		edges_before = ck_edges;
		dones_before = done_pulses;
		send_cmd(sc_pkg::OP_START, 12'h000);
		repeat (40) @(posedge Clk_Out_2_All);   // Into the second byte
		check_level("busy_o mid-frame", busy_o, 1'b1);
		write_gain(10'h2a5);
		send_cmd(sc_pkg::OP_START, 12'h000);    // Arrives while busy, lost
		wait_done();
		check_bits("frozen frame: sr_in_o frame", rx_bits, exp_old);
		repeat (600) @(posedge Clk_Out_2_All);  // Longer than one frame
		check_count("frozen frame: done_o pulses", done_pulses - dones_before, 1);
		check_count("frozen frame: sr_ck_o edges", ck_edges - edges_before, 112);
		run_frame("frame after gain write");
	endtask

	task automatic test_unknown_opcodes();
		send_cmd(4'h0, 12'($urandom()));
		for (int op = 8; op < 16; op++)
			send_cmd(4'(op), 12'($urandom()));
		run_frame("unknown opcodes");
	endtask

	initial
	begin
		void'($urandom(32'h10dd_dce7));
		Clk_Out_2_All = 1'b0;
		reset_i       = 1'b1;
		cmd_i         = '0;
		cmd_valid_i   = 1'b0;
		model_cfg     = '{dac_gain: 10'd0, dac_trig: 10'd0, fb_cap: 4'd0,
			delay_trig: sc_pkg::DELAY_TRIG_RST, val_evt: 1'b1, only_ex_trig: 1'b0, mask: 64'd0};
		repeat (16) @(posedge Clk_Out_2_All);
		#1;
		reset_i = 1'b0;
		test_defaults();
		test_field_writes();
		test_mask();
		test_frozen_frame();
		test_unknown_opcodes();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/sc_pkg.sv
design/sc_cmd_decoder.sv
design/sc_frame_packer.sv
design/sc_sr_shifter.sv
design/sc_config_top.sv
verif/tb_sc_config.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the slow-control testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_sc_config \
	-f filelist.f -o sim_sc_config &&
./obj_dir/sim_sc_config | tee /dev/stderr | grep -q "^TEST PASS$" &&
{ echo "Simulation passed"; exit 0; } ||
{ echo "Simulation failed"; exit 1; }
